// ==== Bender.yml ====
package:
  name: mpmem_2r2w

sources:
  - include_dirs:
      - common
    files:
      - common/mpmem_pkg.sv
      - bank/sram_1r1w.sv
      - bank/write_bank.sv
      - lvt/live_value_table.sv
      - rtl/read_select.sv
      - rtl/mpmem_2r2w_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/mpmem_checker.sv
      - verification/mpmem_assert.sv
      - verification/tb_mpmem.sv

// ==== bank/sram_1r1w.sv ====
`timescale 1ns/1ps

module sram_1r1w #(
  parameter int WIDTH = 16,
  parameter int DEPTH = 256,
  localparam int AWIDTH = $clog2(DEPTH)
) (
  input  logic              clk,
  input  logic              we,
  input  logic [AWIDTH-1:0] waddr,
  input  logic [WIDTH-1:0]  wdata,
  input  logic [AWIDTH-1:0] raddr,
  output logic [WIDTH-1:0]  rdata
);

  logic [WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Registered read, a same-edge write is not seen yet
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

// ==== bank/write_bank.sv ====
`timescale 1ns/1ps
`include "mpmem_config.svh"

module write_bank (
  input  logic               clk,
  input  mpmem_pkg::wr_req_t wr,
  input  logic               wr_en,
  input  mpmem_pkg::adr_t    rd_adr [`MPMEM_NUMRDPT],
  output mpmem_pkg::data_t   rd_data [`MPMEM_NUMRDPT]
);

  import mpmem_pkg::*;

  logic  wr_fire;
  adr_t  wr_adr;
  data_t wr_din;

  // Write is taken only while the memory is ready
  assign wr_fire = wr.write & wr_en;
  assign wr_adr  = wr.adr;
  assign wr_din  = wr.din;

  // One copy per read port, every copy takes the same write
  for (genvar i = 0; i < `MPMEM_NUMRDPT; i++) begin : g_copy
    sram_1r1w #(
      .WIDTH(`MPMEM_WIDTH),
      .DEPTH(`MPMEM_NUMADDR)
    ) copy (
      .clk  (clk),
      .we   (wr_fire),
      .waddr(wr_adr),
      .wdata(wr_din),
      .raddr(rd_adr[i]),
      .rdata(rd_data[i])
    );
  end

endmodule

// ==== common/mpmem_config.svh ====
`ifndef MPMEM_CONFIG_SVH
`define MPMEM_CONFIG_SVH

// Data word width in bits
`define MPMEM_WIDTH 16

// Number of words in the memory
`define MPMEM_NUMADDR 256

// Address width, log2 of the depth
`define MPMEM_BITADDR 8

// Read ports, also the number of copies per bank
`define MPMEM_NUMRDPT 2

`endif

// ==== common/mpmem_pkg.sv ====
`include "mpmem_config.svh"

package mpmem_pkg;

  // Two write ports, one bank each
  localparam int NUMWRPT = 2;

  typedef logic [`MPMEM_BITADDR-1:0] adr_t;
  typedef logic [`MPMEM_WIDTH-1:0] data_t;

  // Write request, one per write port
  typedef struct packed {
    logic  write;
    adr_t  adr;
    data_t din;
  } wr_req_t;

  // Read request, one per read port
  typedef struct packed {
    logic read;
    adr_t adr;
  } rd_req_t;

  // Read response, valid one cycle after the read
  typedef struct packed {
    logic  vld;
    data_t dout;
  } rd_rsp_t;

endpackage

// ==== lvt/live_value_table.sv ====
`timescale 1ns/1ps
`include "mpmem_config.svh"

module live_value_table (
  input  logic                      clk,
  input  logic                      rst,
  input  mpmem_pkg::wr_req_t        wr [mpmem_pkg::NUMWRPT],
  input  mpmem_pkg::adr_t           rd_adr [`MPMEM_NUMRDPT],
  output logic [`MPMEM_NUMRDPT-1:0] sel,
  output logic                      ready
);

  import mpmem_pkg::*;

  // One bit per word, set when write port 1 wrote it last
  logic lvt [`MPMEM_NUMADDR];

  adr_t clr_adr;
  logic clr_en;
  logic clr_last;
  logic tbl_we [NUMWRPT];

  assign clr_en   = ~ready & ~rst;
  assign clr_last = (clr_adr == adr_t'(`MPMEM_NUMADDR - 1));

  always_comb begin
    for (int p = 0; p < NUMWRPT; p++) begin
      tbl_we[p] = wr[p].write & ready;
    end
  end

  // Sweep counter, ready rises after the last entry is cleared
  always_ff @(posedge clk) begin
    if (rst) begin
      clr_adr <= '0;
      ready   <= 1'b0;
    end else if (clr_en) begin
      clr_adr <= clr_adr + 1'b1;
      if (clr_last) begin
        ready <= 1'b1;
      end
    end
  end

  // Port 1 is applied last so it wins a shared address
  always_ff @(posedge clk) begin
    if (clr_en) begin
      lvt[clr_adr] <= 1'b0;
    end else begin
      for (int p = 0; p < NUMWRPT; p++) begin
        if (tbl_we[p]) begin
          lvt[wr[p].adr] <= 1'(p);
        end
      end
    end
  end

  // Registered lookup, lines up with the bank read data
  always_ff @(posedge clk) begin
    for (int i = 0; i < `MPMEM_NUMRDPT; i++) begin
      sel[i] <= lvt[rd_adr[i]];
    end
  end

endmodule

// ==== rtl/mpmem_2r2w_top.sv ====
`timescale 1ns/1ps
`include "mpmem_config.svh"

module mpmem_2r2w_top (
  input  logic               clk,
  input  logic               rst,
  input  mpmem_pkg::wr_req_t wr [mpmem_pkg::NUMWRPT],
  input  mpmem_pkg::rd_req_t rd [`MPMEM_NUMRDPT],
  output mpmem_pkg::rd_rsp_t rsp [`MPMEM_NUMRDPT],
  output logic               ready
);

  import mpmem_pkg::*;

  logic                      rst_q;
  logic                      rst_int;
  adr_t                      rd_adr [`MPMEM_NUMRDPT];
  data_t                     bank0_data [`MPMEM_NUMRDPT];
  data_t                     bank1_data [`MPMEM_NUMRDPT];
  logic [`MPMEM_NUMRDPT-1:0] sel;

  // Internal reset holds only once rst was seen on two edges
  always_ff @(posedge clk) begin
    rst_q <= rst;
  end

  assign rst_int = rst_q & rst;

  always_comb begin
    for (int i = 0; i < `MPMEM_NUMRDPT; i++) begin
      rd_adr[i] = rd[i].adr;
    end
  end

  // Write port 0 owns bank 0
  write_bank bank0 (
    .clk    (clk),
    .wr     (wr[0]),
    .wr_en  (ready),
    .rd_adr (rd_adr),
    .rd_data(bank0_data)
  );

  // Write port 1 owns bank 1
  write_bank bank1 (
    .clk    (clk),
    .wr     (wr[1]),
    .wr_en  (ready),
    .rd_adr (rd_adr),
    .rd_data(bank1_data)
  );

  live_value_table lvt0 (
    .clk   (clk),
    .rst   (rst_int),
    .wr    (wr),
    .rd_adr(rd_adr),
    .sel   (sel),
    .ready (ready)
  );

  read_select rsel0 (
    .clk       (clk),
    .rst       (rst_int),
    .rd        (rd),
    .ready     (ready),
    .sel       (sel),
    .bank0_data(bank0_data),
    .bank1_data(bank1_data),
    .rsp       (rsp)
  );

endmodule

// ==== rtl/read_select.sv ====
`timescale 1ns/1ps
`include "mpmem_config.svh"

module read_select (
  input  logic                      clk,
  input  logic                      rst,
  input  mpmem_pkg::rd_req_t        rd [`MPMEM_NUMRDPT],
  input  logic                      ready,
  input  logic [`MPMEM_NUMRDPT-1:0] sel,
  input  mpmem_pkg::data_t          bank0_data [`MPMEM_NUMRDPT],
  input  mpmem_pkg::data_t          bank1_data [`MPMEM_NUMRDPT],
  output mpmem_pkg::rd_rsp_t        rsp [`MPMEM_NUMRDPT]
);

  import mpmem_pkg::*;

  logic [`MPMEM_NUMRDPT-1:0] vld_q;
  data_t                     dout_sel [`MPMEM_NUMRDPT];

  // A read counts only while ready
  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q <= '0;
    end else begin
      for (int i = 0; i < `MPMEM_NUMRDPT; i++) begin
        vld_q[i] <= rd[i].read & ready;
      end
    end
  end

  // Pick the bank that holds the live value
  always_comb begin
    for (int i = 0; i < `MPMEM_NUMRDPT; i++) begin
      dout_sel[i] = sel[i] ? bank1_data[i] : bank0_data[i];
    end
  end

  always_comb begin
    for (int i = 0; i < `MPMEM_NUMRDPT; i++) begin
      rsp[i].vld  = vld_q[i];
      rsp[i].dout = dout_sel[i];
    end
  end

endmodule

// ==== sources.f ====
+incdir+common
common/mpmem_pkg.sv
bank/sram_1r1w.sv
bank/write_bank.sv
lvt/live_value_table.sv
rtl/read_select.sv
rtl/mpmem_2r2w_top.sv
verification/mpmem_checker.sv
verification/mpmem_assert.sv
verification/tb_mpmem.sv

// ==== verification/mpmem_assert.sv ====
`timescale 1ns/1ps
`include "mpmem_config.svh"

module mpmem_assert (
  input logic               clk,
  input logic               rst,
  input mpmem_pkg::rd_req_t rd [`MPMEM_NUMRDPT],
  input mpmem_pkg::rd_rsp_t rsp [`MPMEM_NUMRDPT],
  input logic               ready
);

  int fail_count = 0;

  for (genvar i = 0; i < `MPMEM_NUMRDPT; i++) begin : g_port
    // vld only follows a read accepted on the previous edge
    vld_after_read: assert property (@(posedge clk) disable iff (rst)
      rsp[i].vld |-> $past(rd[i].read && ready))
      else begin
        $error("rsp[%0d].vld without an accepted read", i);
        fail_count++;
      end

    // Internal reset needs rst on two edges, vld is low one edge later
    vld_low_in_reset: assert property (@(posedge clk)
      rst && $past(rst) |=> !rsp[i].vld)
      else begin
        $error("rsp[%0d].vld high during reset", i);
        fail_count++;
      end

    vld_needs_ready: assert property (@(posedge clk) disable iff (rst)
      !ready |-> !rsp[i].vld)
      else begin
        $error("rsp[%0d].vld high while ready is low", i);
        fail_count++;
      end
  end

endmodule

bind mpmem_2r2w_top mpmem_assert sva0 (
  .clk  (clk),
  .rst  (rst),
  .rd   (rd),
  .rsp  (rsp),
  .ready(ready)
);

// ==== verification/mpmem_checker.sv ====
`timescale 1ns/1ps
`include "mpmem_config.svh"

module mpmem_checker (
  input  logic               clk,
  input  logic               rst,
  input  mpmem_pkg::wr_req_t wr [mpmem_pkg::NUMWRPT],
  input  mpmem_pkg::rd_req_t rd [`MPMEM_NUMRDPT],
  input  mpmem_pkg::rd_rsp_t rsp [`MPMEM_NUMRDPT],
  input  logic               ready,
  input  logic               done,
  input  int                 assert_errors,
  output int                 error_count
);

  import mpmem_pkg::*;

  data_t shadow [`MPMEM_NUMADDR];
  bit    written [`MPMEM_NUMADDR];
  // Data of writes sent before ready, which must never be read back
  data_t stale_din [`MPMEM_NUMADDR];
  bit    stale [`MPMEM_NUMADDR];
  bit    exp_vld [`MPMEM_NUMRDPT];
  bit    exp_known [`MPMEM_NUMRDPT];
  bit    exp_stale [`MPMEM_NUMRDPT];
  data_t exp_dout [`MPMEM_NUMRDPT];
  data_t stale_dout [`MPMEM_NUMRDPT];
  logic  ready_q = 1'b0;
  logic  rst_q = 1'b0;
  int    data_errors = 0;
  int    vld_errors = 0;
  int    other_errors = 0;
  int    ready_rises = 0;
  int    compared = 0;

  assign error_count = data_errors + vld_errors + other_errors + assert_errors;

  // Word value after one cycle of writes, port 1 wins a shared address
  function automatic data_t ref_word(data_t cur, adr_t a, wr_req_t w0, wr_req_t w1);
    data_t val;
    val = cur;
    if (w0.write && w0.adr == a) begin
      val = w0.din;
    end
    if (w1.write && w1.adr == a) begin
      val = w1.din;
    end
    return val;
  endfunction

  always @(posedge clk) begin
    adr_t a;
    if (rst) begin
      for (int i = 0; i < `MPMEM_NUMRDPT; i++) exp_vld[i] = 1'b0;
    end else begin
      // Responses seen now belong to reads taken on the previous edge
      for (int i = 0; i < `MPMEM_NUMRDPT; i++) begin
        if (rsp[i].vld !== exp_vld[i]) begin
          vld_errors++;
          $display("Error rsp[%0d].vld: expected %h, got %h", i, exp_vld[i], rsp[i].vld);
        end else if (exp_vld[i] && exp_known[i]) begin
          compared++;
          if (rsp[i].dout !== exp_dout[i]) begin
            data_errors++;
            $display("Error rsp[%0d].dout: expected %h, got %h", i, exp_dout[i], rsp[i].dout);
          end
        end else if (exp_vld[i] && exp_stale[i] && rsp[i].dout === stale_dout[i]) begin
          data_errors++;
          $display("Error rsp[%0d].dout: got %h, the data of a write sent before ready",
                   i, rsp[i].dout);
        end
      end
      if (rst_q === 1'b1 && ready !== 1'b0) begin
        other_errors++;
        $display("Error ready: expected 0, got %h", ready);
      end
      if (ready === 1'b1 && ready_q !== 1'b1) begin
        ready_rises++;
      end else if (ready_q === 1'b1 && ready !== 1'b1) begin
        other_errors++;
        $display("ready fell while rst was low");
      end
      // Reads see the memory as it was before this edge's writes
      for (int i = 0; i < `MPMEM_NUMRDPT; i++) begin
        a = rd[i].adr;
        exp_vld[i] = (rd[i].read === 1'b1) && (ready === 1'b1);
        exp_known[i] = written[a];
        exp_dout[i] = shadow[a];
        exp_stale[i] = stale[a];
        stale_dout[i] = stale_din[a];
      end
      for (int p = 0; p < NUMWRPT; p++) begin
        if (ready === 1'b1 && wr[p].write === 1'b1) begin
          a = wr[p].adr;
          shadow[a] = ref_word(shadow[a], a, wr[0], wr[1]);
          written[a] = 1'b1;
        end else if (wr[p].write === 1'b1) begin
          a = wr[p].adr;
          stale[a] = 1'b1;
          stale_din[a] = wr[p].din;
        end
      end
    end
    rst_q = rst;
    ready_q = ready;
  end

  always @(posedge done) begin
    if (ready_rises != 1) begin
      other_errors++;
      $display("ready rose %0d times after reset instead of once", ready_rises);
    end
    if (compared == 0) begin
      other_errors++;
      $display("no read data was compared");
    end
    $display("Checker: %0d reads compared, %0d data errors, %0d vld errors, %0d other errors, %0d assertion failures",
             compared, data_errors, vld_errors, other_errors, assert_errors);
  end

endmodule

// ==== verification/tb_mpmem.sv ====
`timescale 1ns/1ps
`include "mpmem_config.svh"

module tb_mpmem;

  import mpmem_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int DRIVE_DELAY = 2;
  localparam int RESET_CYCLES = 5;
  localparam int DIRECTED_CYCLES = 80;
  localparam int RANDOM_CYCLES = 400;
  localparam int TEST_CYCLES = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES;
  localparam int WATCHDOG_NS = (`MPMEM_NUMADDR + TEST_CYCLES + 100) * CLK_PERIOD;
  localparam adr_t POOL_BASE = 8'h60;

  logic    clk;
  logic    rst;
  logic    done;
  logic    ready;
  int      error_count;
  wr_req_t wr [NUMWRPT];
  rd_req_t rd [`MPMEM_NUMRDPT];
  rd_rsp_t rsp [`MPMEM_NUMRDPT];

  mpmem_2r2w_top dut0 (
    .clk  (clk),
    .rst  (rst),
    .wr   (wr),
    .rd   (rd),
    .rsp  (rsp),
    .ready(ready)
  );

  mpmem_checker chk0 (
    .clk          (clk),
    .rst          (rst),
    .wr           (wr),
    .rd           (rd),
    .rsp          (rsp),
    .ready        (ready),
    .done         (done),
    .assert_errors(dut0.sva0.fail_count),
    .error_count  (error_count)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("SIMULATION FAILED");
    $finish;
  end

  task automatic clear_requests();
    for (int p = 0; p < NUMWRPT; p++) wr[p] = '0;
    for (int i = 0; i < `MPMEM_NUMRDPT; i++) rd[i] = '0;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
    clear_requests();
  endtask

  task automatic set_write(int p, adr_t a, data_t d);
    wr[p].write = 1'b1;
    wr[p].adr = a;
    wr[p].din = d;
  endtask

  task automatic set_read(int i, adr_t a);
    rd[i].read = 1'b1;
    rd[i].adr = a;
  endtask

  task automatic read_all(adr_t a);
    for (int i = 0; i < `MPMEM_NUMRDPT; i++) set_read(i, a);
  endtask

  // Write on one port, read back on every port in the next cycle
  task automatic write_then_read(int p, adr_t a, data_t d);
    set_write(p, a, d);
    next_cycle();
    read_all(a);
    next_cycle();
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (ready !== 1'b1 && n < `MPMEM_NUMADDR + 20) begin
      next_cycle();
      n++;
    end
    if (ready !== 1'b1) $display("ready did not rise within %0d cycles after reset", n);
  endtask

  initial begin
    void'($urandom(32'h7f83d5ad));
    rst = 1'b1;
    done = 1'b0;
    clear_requests();
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;

    // Requests during the clear sweep are ignored
    for (int n = 0; n < 10; n++) begin
      set_write(n % NUMWRPT, adr_t'(8'h10 + n), 16'hdead);
      read_all(adr_t'(8'h10 + n));
      next_cycle();
    end
    wait_ready();

    // Words sent during the sweep were never stored
    for (int n = 0; n < 10; n++) begin
      read_all(adr_t'(8'h10 + n));
      next_cycle();
    end

    for (int p = 0; p < NUMWRPT; p++) begin
      for (int k = 0; k < 4; k++) begin
        write_then_read(p, adr_t'(8'h20 + 4 * p + k), data_t'(16'h1100 * (p + 1) + k));
      end
    end

    // Alternating writers to one address
    write_then_read(0, 8'h30, 16'h3000);
    write_then_read(1, 8'h30, 16'h3001);
    write_then_read(0, 8'h30, 16'h3002);
    write_then_read(1, 8'h30, 16'h3003);
    write_then_read(1, 8'h30, 16'h3004);
    write_then_read(0, 8'h30, 16'h3005);

    for (int k = 0; k < 3; k++) begin
      set_write(0, adr_t'(8'h40 + k), data_t'(16'h4a00 + k));
      set_write(1, adr_t'(8'h40 + k), data_t'(16'h4b00 + k));
      next_cycle();
      read_all(adr_t'(8'h40 + k));
      next_cycle();
    end

    // Read in the same cycle as a write to that address
    set_write(0, 8'h50, 16'h5000);
    next_cycle();
    set_write(1, 8'h50, 16'h5111);
    read_all(8'h50);
    next_cycle();
    read_all(8'h50);
    next_cycle();

    // Fill the pool so random reads only hit written words
    for (int k = 0; k < 16; k++) begin
      set_write(0, POOL_BASE + adr_t'(2 * k), data_t'($urandom));
      set_write(1, POOL_BASE + adr_t'(2 * k + 1), data_t'($urandom));
      next_cycle();
    end
    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      for (int p = 0; p < NUMWRPT; p++) begin
        if ($urandom_range(1, 0) == 1) begin
          set_write(p, POOL_BASE + adr_t'($urandom_range(31, 0)), data_t'($urandom));
        end
      end
      for (int i = 0; i < `MPMEM_NUMRDPT; i++) begin
        if ($urandom_range(3, 0) != 0) set_read(i, POOL_BASE + adr_t'($urandom_range(31, 0)));
      end
      next_cycle();
    end
    repeat (3) next_cycle();

    done = 1'b1;
    #1;
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
